// ==== verilog/core_glue_pkg.sv ====
/*
  Shared types and constants for the core glue logic.
  Holds the bridge, settings, data table and video structs, the bridge
  register map and the read regions. Used by the RTL and the testbench.
*/

`default_nettype none

package core_glue_pkg;

  //////////////////////////////
  // structs
  //////////////////////////////

  typedef struct packed {
    logic [31:0] addr;
    logic        rd;
    logic        wr;
    logic [31:0] wr_data;
  } bridge_req_t;

  typedef struct packed {
    logic [1:0] system;
    logic       cpu_turbo;
    logic       triple_buffer;
    logic [1:0] flickerblend;
    logic [1:0] orientation;
    logic       flip_horizontal;
    logic       fastforward_sound;
  } settings_t;

  // download flags are {colour, black-and-white}
  typedef struct packed {
    logic [1:0] ext_cart_download;
    logic [1:0] bios_download;
    logic       save_download;
    logic       external_reset;
  } load_ctrl_t;

  typedef struct packed {
    logic [9:0]  addr;
    logic        wren;
    logic [31:0] data;
  } datatable_wr_t;

  typedef struct packed {
    logic        hblank;
    logic        vblank;
    logic        hs;
    logic        vs;
    logic        is_vertical;
    logic [23:0] rgb;
  } video_core_t;

  typedef struct packed {
    logic [23:0] rgb;
    logic        de;
    logic        hs;
    logic        vs;
  } video_out_t;

  //////////////////////////////
  // bridge write map
  //////////////////////////////

  localparam logic [31:0] addr_cart_download = 32'h000;
  localparam logic [31:0] addr_is_color_cart = 32'h004;
  localparam logic [31:0] addr_bw_bios       = 32'h008;
  localparam logic [31:0] addr_color_bios    = 32'h00C;
  localparam logic [31:0] addr_save_download = 32'h010;
  localparam logic [31:0] addr_reset         = 32'h050;
  localparam logic [31:0] addr_system        = 32'h100;
  localparam logic [31:0] addr_turbo         = 32'h110;
  localparam logic [31:0] addr_triple_buffer = 32'h200;
  localparam logic [31:0] addr_flickerblend  = 32'h204;
  localparam logic [31:0] addr_orientation   = 32'h208;
  localparam logic [31:0] addr_flip          = 32'h20C;
  localparam logic [31:0] addr_ff_sound      = 32'h300;

  // read regions match the top byte or the top nibble
  localparam logic [7:0] region_cmd   = 8'hF8;
  localparam logic [3:0] region_save  = 4'h2;
  localparam logic [3:0] region_state = 4'h4;

  // data table word holding the slot 3 size
  localparam logic [9:0]  save_slot_table_addr = 10'd7;
  localparam logic [31:0] save_block_bytes     = 32'd512;
  localparam logic [31:0] rtc_extra_bytes      = 32'd12;

  // orientation codes 1 and 3 both mean horizontal
  localparam logic [1:0] orient_auto     = 2'd0;
  localparam logic [1:0] orient_vertical = 2'd2;
  localparam int         slot_orient_bit = 13;

endpackage

`default_nettype wire

// ==== verilog/bridge_settings.sv ====
/*
  Settings register file on the host bridge.
  Decodes bridge writes into download flags, user settings and a delayed
  core reset, and muxes read data from the external sources by region.
*/

`default_nettype none

module bridge_settings #(
  parameter logic [31:0] reset_delay_cycles = 32'd1048576
) (
  input  wire                        clk_74a,
  input  wire                        pll_core_locked,
  input  wire core_glue_pkg::bridge_req_t bridge,
  input  wire [31:0]                 cmd_rd_data,
  input  wire [31:0]                 save_rd_data,
  input  wire [31:0]                 state_rd_data,
  output logic [31:0]                bridge_rd_data,
  output core_glue_pkg::settings_t   settings,
  output core_glue_pkg::load_ctrl_t  load_ctrl
);

  import core_glue_pkg::*;

  // download flags
  logic cart_download;
  logic is_color_cart;
  logic bw_bios_download;
  logic color_bios_download;
  logic save_download;

  // remaining cycles of core reset
  logic [31:0] reset_delay;

  //////////////////////////////
  // write decode
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      cart_download       <= 1'b0;
      is_color_cart       <= 1'b0;
      bw_bios_download    <= 1'b0;
      color_bios_download <= 1'b0;
      save_download       <= 1'b0;
      reset_delay         <= '0;
      settings            <= '0;
    end else begin
      if (reset_delay != '0) begin
        reset_delay <= reset_delay - 32'd1;
      end

      if (bridge.wr) begin
        case (bridge.addr)
          addr_cart_download: begin
            cart_download <= bridge.wr_data[0];
          end
          addr_is_color_cart: begin
            is_color_cart <= bridge.wr_data[0];
          end
          addr_bw_bios: begin
            bw_bios_download <= bridge.wr_data[0];
          end
          addr_color_bios: begin
            color_bios_download <= bridge.wr_data[0];
          end
          addr_save_download: begin
            save_download <= bridge.wr_data[0];
          end
          // a new write restarts the count
          addr_reset: begin
            reset_delay <= reset_delay_cycles;
          end
          addr_system: begin
            settings.system <= bridge.wr_data[1:0];
          end
          addr_turbo: begin
            settings.cpu_turbo <= bridge.wr_data[0];
          end
          addr_triple_buffer: begin
            settings.triple_buffer <= bridge.wr_data[0];
          end
          addr_flickerblend: begin
            settings.flickerblend <= bridge.wr_data[1:0];
          end
          addr_orientation: begin
            settings.orientation <= bridge.wr_data[1:0];
          end
          addr_flip: begin
            settings.flip_horizontal <= bridge.wr_data[0];
          end
          addr_ff_sound: begin
            settings.fastforward_sound <= bridge.wr_data[0];
          end
          default: begin
          end
        endcase
      end
    end
  end

  //////////////////////////////
  // load controls
  //////////////////////////////

  // cart flag lands on the colour or the b/w bit
  assign load_ctrl.ext_cart_download = is_color_cart ? {cart_download, 1'b0}
                                                     : {1'b0, cart_download};
  assign load_ctrl.bios_download     = {color_bios_download, bw_bios_download};
  assign load_ctrl.save_download     = save_download;
  assign load_ctrl.external_reset    = (reset_delay != '0);

  //////////////////////////////
  // read mux
  //////////////////////////////

  always_comb begin
    if (bridge.addr[31:24] == region_cmd) begin
      bridge_rd_data = cmd_rd_data;
    end else if (bridge.addr[31:28] == region_save) begin
      bridge_rd_data = save_rd_data;
    end else if (bridge.addr[31:28] == region_state) begin
      bridge_rd_data = state_rd_data;
    end else begin
      bridge_rd_data = '0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/datatable_writer.sv ====
/*
  Keeps the host data table up to date with the save memory size.
  Writes the byte count of data slot 3 to its table word every cycle.
*/

`default_nettype none

module datatable_writer (
  input  wire                          clk_74a,
  input  wire                          pll_core_locked,
  input  wire [11:0]                   save_size,
  input  wire                          has_rtc,
  output core_glue_pkg::datatable_wr_t datatable
);

  import core_glue_pkg::*;

  logic [31:0] save_bytes;

  // save_size counts 512 byte blocks and the rtc adds 12 bytes
  always_comb begin
    save_bytes = 32'(save_size) * save_block_bytes;
    if (has_rtc) begin
      save_bytes = save_bytes + rtc_extra_bytes;
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable <= '0;
    end else begin
      datatable.wren <= 1'b1;
      datatable.addr <= save_slot_table_addr;
      datatable.data <= save_bytes;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/video_conditioner.sv ====
/*
  Turns core video timing into scaler video.
  Registers pixels and data enable, sends the orientation slot word in the
  first blank cycle, and shapes vsync and a delayed hsync into pulses.
*/

`default_nettype none

module video_conditioner #(
  parameter logic [2:0] hsync_delay = 3'd7
) (
  input  wire                        clk_74a,
  input  wire                        pll_core_locked,
  input  wire core_glue_pkg::video_core_t video_in,
  input  wire [1:0]                  orientation,
  output core_glue_pkg::video_out_t  video_out
);

  import core_glue_pkg::*;

  logic        de;
  logic        de_prev;
  logic        hs_prev;
  logic        vs_prev;
  logic [2:0]  hs_count;
  logic        orient_bit;
  logic [23:0] slot_rgb;

  assign de = ~(video_in.hblank | video_in.vblank);

  // auto follows the core and any other code but 2 is horizontal
  assign orient_bit = (orientation == orient_auto) ? video_in.is_vertical
                                                   : (orientation == orient_vertical);

  always_comb begin
    slot_rgb = '0;
    slot_rgb[slot_orient_bit] = orient_bit;
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_out <= '0;
      de_prev   <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      hs_count  <= '0;
    end else begin
      video_out.de <= de;

      if (de) begin
        video_out.rgb <= video_in.rgb;
      end else if (de_prev) begin
        // falling edge of de
        video_out.rgb <= slot_rgb;
      end else begin
        video_out.rgb <= '0;
      end

      // single cycle vsync on the rising edge
      video_out.vs <= video_in.vs & ~vs_prev;

      // hsync pushed back so it never lands on vsync
      if (video_in.hs && !hs_prev) begin
        hs_count <= hsync_delay;
      end else if (hs_count != '0) begin
        hs_count <= hs_count - 3'd1;
      end
      video_out.hs <= (hs_count == 3'd1);

      de_prev <= de;
      hs_prev <= video_in.hs;
      vs_prev <= video_in.vs;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/core_glue_top.sv ====
/*
  Top level of the core glue logic on clk_74a.
  Wires the bridge settings, the data table writer and the video
  conditioner together and hands the parameters down.
*/

`default_nettype none

module core_glue_top #(
  parameter logic [31:0] reset_delay_cycles = 32'd1048576,
  parameter logic [2:0]  hsync_delay        = 3'd7
) (
  input  wire                             clk_74a,
  input  wire                             pll_core_locked,

  // host bridge
  input  wire core_glue_pkg::bridge_req_t bridge,
  input  wire [31:0]                      cmd_rd_data,
  input  wire [31:0]                      save_rd_data,
  input  wire [31:0]                      state_rd_data,
  output wire [31:0]                      bridge_rd_data,

  // core side
  input  wire [11:0]                      save_size,
  input  wire                             has_rtc,
  input  wire core_glue_pkg::video_core_t video_in,

  output wire core_glue_pkg::settings_t   settings,
  output wire core_glue_pkg::load_ctrl_t  load_ctrl,
  output wire core_glue_pkg::datatable_wr_t datatable,
  output wire core_glue_pkg::video_out_t  video_out
);

  //////////////////////////////
  // bridge registers
  //////////////////////////////

  bridge_settings #(
    .reset_delay_cycles(reset_delay_cycles)
  ) settings_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge         (bridge),
    .cmd_rd_data    (cmd_rd_data),
    .save_rd_data   (save_rd_data),
    .state_rd_data  (state_rd_data),
    .bridge_rd_data (bridge_rd_data),
    .settings       (settings),
    .load_ctrl      (load_ctrl)
  );

  datatable_writer datatable_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .save_size      (save_size),
    .has_rtc        (has_rtc),
    .datatable      (datatable)
  );

  //////////////////////////////
  // video
  //////////////////////////////

  video_conditioner #(
    .hsync_delay(hsync_delay)
  ) video_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .video_in       (video_in),
    .orientation    (settings.orientation),
    .video_out      (video_out)
  );

endmodule

`default_nettype wire

// ==== dv/core_glue_checks.svh ====
/*
  Compare tasks for the core glue testbench, one per result type.
  Included inside the testbench module after the package import.
*/

`ifndef core_glue_checks_svh
`define core_glue_checks_svh

task automatic check_settings(input string name, input settings_t got,
                              input settings_t exp);
  if (got !== exp) begin
    $display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
    stop_run();
  end
endtask

task automatic check_load_ctrl(input string name, input load_ctrl_t got,
                               input load_ctrl_t exp);
  if (got !== exp) begin
    $display("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp);
    stop_run();
  end
endtask

task automatic check_rd_data(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
  if (got !== exp) begin
    $display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
    stop_run();
  end
endtask

task automatic check_datatable(input string name, input datatable_wr_t got,
                               input datatable_wr_t exp);
  if (got !== exp) begin
    $display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
    stop_run();
  end
endtask

task automatic check_video(input string name, input video_out_t got,
                           input video_out_t exp);
  if (got !== exp) begin
    $display("MISMATCH time=%0t %s got=rgb %h de %b hs %b vs %b exp=rgb %h de %b hs %b vs %b",
             $time, name, got.rgb, got.de, got.hs, got.vs,
             exp.rgb, exp.de, exp.hs, exp.vs);
    stop_run();
  end
endtask

`endif

// ==== dv/core_glue_tb.sv ====
/*
  Testbench for core_glue_top. Drives bridge writes and reads, save size
  and synthetic video frames, keeps a reference model in step with the DUT
  and compares every output on each falling clock edge.
*/

`default_nettype none

module core_glue_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import core_glue_pkg::*;

  localparam logic [31:0] reset_cycles  = 32'd40;
  localparam int          hs_delay      = 7;
  localparam int          reset_timeout = 500;

  localparam logic [31:0] wr_addrs [13] = '{
    addr_cart_download, addr_is_color_cart, addr_bw_bios, addr_color_bios,
    addr_save_download, addr_reset, addr_system, addr_turbo, addr_triple_buffer,
    addr_flickerblend, addr_orientation, addr_flip, addr_ff_sound
  };

  // stored download flags of the model
  typedef struct packed {
    logic cart;
    logic color_cart;
    logic bw_bios;
    logic color_bios;
    logic save;
  } dl_flags_t;

  logic          clk_74a;
  logic          pll_core_locked;
  bridge_req_t   bridge;
  logic [31:0]   cmd_rd_data;
  logic [31:0]   save_rd_data;
  logic [31:0]   state_rd_data;
  logic [31:0]   bridge_rd_data;
  logic [11:0]   save_size;
  logic          has_rtc;
  video_core_t   video_in;
  settings_t     settings;
  load_ctrl_t    load_ctrl;
  datatable_wr_t datatable;
  video_out_t    video_out;

  // reference model state
  settings_t     exp_settings;
  load_ctrl_t    exp_load;
  datatable_wr_t exp_dt;
  video_out_t    exp_video;
  dl_flags_t     flags;
  logic [31:0]   reset_left;
  logic          de_prev_m;
  logic          hs_prev_m;
  logic          vs_prev_m;
  logic          hs_pulse;
  int            edge_n;
  int            last_hs_rise;

  logic          check_en;
  logic [31:0]   rng_state = 32'h90dd;

  core_glue_top #(
    .reset_delay_cycles(reset_cycles)
  ) dut_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge         (bridge),
    .cmd_rd_data    (cmd_rd_data),
    .save_rd_data   (save_rd_data),
    .state_rd_data  (state_rd_data),
    .bridge_rd_data (bridge_rd_data),
    .save_size      (save_size),
    .has_rtc        (has_rtc),
    .video_in       (video_in),
    .settings       (settings),
    .load_ctrl      (load_ctrl),
    .datatable      (datatable),
    .video_out      (video_out)
  );

  task automatic stop_run();
    $display("Test failures found");
    $fatal(1, "simulation stopped at first error");
  endtask

  `include "core_glue_checks.svh"

  function automatic logic [31:0] rand32();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  //////////////////////////////
  // reference functions
  //////////////////////////////

  function automatic settings_t settings_next(settings_t s, bridge_req_t b);
    settings_t n;
    n = s;
    if (b.wr) begin
      case (b.addr)
        addr_system:        n.system = b.wr_data[1:0];
        addr_turbo:         n.cpu_turbo = b.wr_data[0];
        addr_triple_buffer: n.triple_buffer = b.wr_data[0];
        addr_flickerblend:  n.flickerblend = b.wr_data[1:0];
        addr_orientation:   n.orientation = b.wr_data[1:0];
        addr_flip:          n.flip_horizontal = b.wr_data[0];
        addr_ff_sound:      n.fastforward_sound = b.wr_data[0];
        default: ;
      endcase
    end
    return n;
  endfunction

  function automatic dl_flags_t flags_next(dl_flags_t f, bridge_req_t b);
    dl_flags_t n;
    n = f;
    if (b.wr) begin
      case (b.addr)
        addr_cart_download: n.cart = b.wr_data[0];
        addr_is_color_cart: n.color_cart = b.wr_data[0];
        addr_bw_bios:       n.bw_bios = b.wr_data[0];
        addr_color_bios:    n.color_bios = b.wr_data[0];
        addr_save_download: n.save = b.wr_data[0];
        default: ;
      endcase
    end
    return n;
  endfunction

  function automatic load_ctrl_t load_ctrl_expect(dl_flags_t f, logic rst_active);
    load_ctrl_t l;
    // colour cart on bit 1 and b/w cart on bit 0
    l.ext_cart_download = {f.cart & f.color_cart, f.cart & ~f.color_cart};
    l.bios_download     = {f.color_bios, f.bw_bios};
    l.save_download     = f.save;
    l.external_reset    = rst_active;
    return l;
  endfunction

  function automatic logic [31:0] rd_data_expect(logic [31:0] addr, logic [31:0] cmd,
                                                 logic [31:0] save, logic [31:0] state);
    if (addr[31:24] == 8'hF8) begin
      return cmd;
    end else if (addr[31:28] == 4'h2) begin
      return save;
    end else if (addr[31:28] == 4'h4) begin
      return state;
    end
    return 32'd0;
  endfunction

  // 512 byte blocks plus 12 bytes of rtc
  function automatic logic [31:0] save_bytes_expect(logic [11:0] size, logic rtc);
    return {11'd0, size, 9'd0} + (rtc ? 32'd12 : 32'd0);
  endfunction

  function automatic video_out_t video_expect(video_core_t v, logic [1:0] orient,
                                              logic de_prev, logic hs_p, logic vs_prev);
    video_out_t o;
    logic       vert;
    o = '0;
    o.de = ~(v.hblank | v.vblank);
    if (orient == 2'd0) begin
      vert = v.is_vertical;
    end else begin
      vert = (orient == 2'd2);
    end
    if (o.de) begin
      o.rgb = v.rgb;
    end else if (de_prev) begin
      o.rgb = {10'd0, vert, 13'd0};
    end
    o.vs = v.vs & ~vs_prev;
    o.hs = hs_p;
    return o;
  endfunction

  //////////////////////////////
  // model and compare
  //////////////////////////////

  always @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      exp_settings = '0;
      exp_load     = '0;
      exp_dt       = '0;
      exp_video    = '0;
      flags        = '0;
      reset_left   = '0;
      de_prev_m    = 1'b0;
      hs_prev_m    = 1'b0;
      vs_prev_m    = 1'b0;
      edge_n       = 0;
      last_hs_rise = -1000;
    end else begin
      // video uses the orientation held before this edge
      hs_pulse  = ((edge_n - last_hs_rise) == hs_delay);
      exp_video = video_expect(video_in, exp_settings.orientation, de_prev_m,
                               hs_pulse, vs_prev_m);
      if (video_in.hs && !hs_prev_m) begin
        last_hs_rise = edge_n;
      end
      de_prev_m = ~(video_in.hblank | video_in.vblank);
      hs_prev_m = video_in.hs;
      vs_prev_m = video_in.vs;
      edge_n++;

      exp_settings = settings_next(exp_settings, bridge);
      flags        = flags_next(flags, bridge);
      if (reset_left != '0) begin
        reset_left = reset_left - 32'd1;
      end
      if (bridge.wr && bridge.addr == addr_reset) begin
        reset_left = reset_cycles;
      end
      exp_load = load_ctrl_expect(flags, reset_left != '0);

      exp_dt.addr = 10'd7;
      exp_dt.wren = 1'b1;
      exp_dt.data = save_bytes_expect(save_size, has_rtc);
    end
  end

  always @(negedge clk_74a) begin
    if (check_en) begin
      check_settings("settings", settings, exp_settings);
      check_load_ctrl("load_ctrl", load_ctrl, exp_load);
      check_rd_data("bridge_rd_data", bridge_rd_data,
                    rd_data_expect(bridge.addr, cmd_rd_data, save_rd_data, state_rd_data));
      check_datatable("datatable", datatable, exp_dt);
      check_video("video_out", video_out, exp_video);
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    clk_74a = 1'b0;
    forever #5 clk_74a = ~clk_74a;
  end

  task automatic next_cycle();
    logic [31:0] r;
    @(posedge clk_74a);
    #1;
    cmd_rd_data   = rand32();
    save_rd_data  = rand32();
    state_rd_data = rand32();
    r             = rand32();
    save_size     = r[11:0];
    has_rtc       = r[12];
  endtask

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    bridge.addr    = addr;
    bridge.rd      = 1'b0;
    bridge.wr      = 1'b1;
    bridge.wr_data = data;
    next_cycle();
    bridge.wr = 1'b0;
  endtask

  // counts the cycles with external_reset high after a write
  task automatic check_reset_length();
    int cycles;
    cycles = 0;
    while (load_ctrl.external_reset) begin
      cycles++;
      if (cycles > reset_timeout) begin
        $display("timeout waiting for external_reset to fall at %0t", $time);
        stop_run();
      end
      next_cycle();
    end
    if (cycles != int'(reset_cycles)) begin
      $display("MISMATCH time=%0t external_reset_cycles got=%0d exp=%0d",
               $time, cycles, reset_cycles);
      stop_run();
    end
  endtask

  task automatic run_frame(input logic vert);
    logic [31:0] r;
    for (int line = 0; line < 6; line++) begin
      for (int px = 0; px < 28; px++) begin
        r = rand32();
        video_in.rgb         = r[23:0];
        video_in.hblank      = (px >= 20);
        video_in.vblank      = (line >= 4);
        video_in.hs          = (px >= 22 && px < 25);
        video_in.vs          = (line == 4);
        video_in.is_vertical = vert;
        next_cycle();
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [3:0]  idx;
    pll_core_locked = 1'b0;
    bridge          = '0;
    cmd_rd_data     = '0;
    save_rd_data    = '0;
    state_rd_data   = '0;
    save_size       = '0;
    has_rtc         = 1'b0;
    video_in        = '0;
    check_en        = 1'b0;

    repeat (2) @(posedge clk_74a);
    check_en = 1'b1;
    repeat (6) @(posedge clk_74a);
    #1;
    pll_core_locked = 1'b1;
    repeat (4) next_cycle();

    // random writes to decoded and undecoded addresses
    for (int i = 0; i < 300; i++) begin
      r   = rand32();
      idx = r[3:0];
      if (idx < 4'd13) begin
        a = wr_addrs[idx];
      end else begin
        a = {20'd0, r[15:6], 2'b00};
      end
      bridge_write(a, rand32());
    end

    // delayed reset and a restart in the middle of the count
    bridge_write(addr_reset, rand32());
    check_reset_length();
    bridge_write(addr_reset, rand32());
    repeat (15) next_cycle();
    bridge_write(addr_reset, rand32());
    check_reset_length();

    // read regions
    for (int i = 0; i < 200; i++) begin
      r = rand32();
      case (i % 4)
        0: bridge.addr = {region_cmd, r[23:0]};
        1: bridge.addr = {region_save, r[27:0]};
        2: bridge.addr = {region_state, r[27:0]};
        default: bridge.addr = r;
      endcase
      bridge.rd = 1'b1;
      next_cycle();
    end
    bridge.rd = 1'b0;

    // video frames for every orientation code
    for (int o = 0; o < 4; o++) begin
      for (int v = 0; v < 2; v++) begin
        r = rand32();
        bridge_write(addr_orientation, {r[31:2], o[1:0]});
        run_frame(v[0]);
      end
    end
    repeat (10) next_cycle();

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== core_glue.f ====
+incdir+dv
verilog/core_glue_pkg.sv
verilog/bridge_settings.sv
verilog/datatable_writer.sv
verilog/video_conditioner.sv
verilog/core_glue_top.sv
dv/core_glue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the core_glue testbench with Verilator, run it, check the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module core_glue_tb \
  -f core_glue.f -o core_glue_sim || exit 1

out=$(./obj_dir/core_glue_sim)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx 'All tests passed!' && exit 0 || exit 1
